// File: build.f
+incdir+.
bp_addr_pkg.sv
bp_pred_pkg.sv
btb.sv
bht.sv
bp_update_ctrl.sv
bp_next_pc.sv
branch_predict_top.sv
tb_branch_predict.sv

// File: run_sim.sh
#!/bin/sh
# Build the branch predictor testbench with Verilator, run it and check the log

LOG=sim.log
OBJ=obj_dir

if ! cd "$(dirname "$0")"; then
  echo "Cannot enter the project root"
  exit 1
fi

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -Mdir "$OBJ" --top-module tb_branch_predict -f build.f
if [ $? -ne 0 ]; then
  echo "Compile step failed"
  exit 1
fi

"./$OBJ/Vtb_branch_predict" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
  echo "Simulation PASS"
  exit 0
else
  echo "Simulation FAIL, see $LOG"
  exit 1
fi

// File: tb_branch_predict.sv
// Testbench: clock, reset, random updates, BTB and BHT reference model, checks, error summary
`include "bp_cfg.svh"

module tb_branch_predict;
  timeunit 1ns;
  timeprecision 1ps;

  // About 300 updates of at most 5 cycles, 2 probes each, plus setup and flush probes
  localparam int N_RAND     = 290;
  localparam int MAX_CYCLES = 300 * (5 + 2) + 400;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 flush_i;
  logic                 debug_mode_i;
  bp_addr_pkg::vaddr_t  vpc_i;
  logic                 predict_taken_o;
  bp_addr_pkg::slot_t   predict_slot_o;
  bp_addr_pkg::vaddr_t  next_pc_o;
  logic                 upd_req_i;
  logic                 upd_taken_i;
  logic                 upd_cond_i;
  bp_addr_pkg::vaddr_t  upd_pc_i;
  bp_pred_pkg::target_t upd_target_i;
  logic                 upd_ack_o;

  integer seed;
  int     value_errors;
  int     proto_errors;
  int     cycles;

  // Reference copy of both tables
  logic                 mdl_valid  [`BP_BTB_ROWS][`BP_INSTR_PER_FETCH];
  bp_pred_pkg::target_t mdl_target [`BP_BTB_ROWS][`BP_INSTR_PER_FETCH];
  logic [1:0]           mdl_cnt    [`BP_BHT_ROWS][`BP_INSTR_PER_FETCH];
  // Update PCs, both slots of six blocks
  bp_addr_pkg::vaddr_t  pc_pool    [12];

  branch_predict_top branch_predict_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
    $display("Regression failed");
    $finish;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic bp_addr_pkg::vaddr_t seq_pc(input bp_addr_pkg::vaddr_t a);
    // Next 4-byte block
    return (a & 32'hFFFF_FFFC) + 32'd4;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("** Error at %0t: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
    end
  endtask

  // BTB row is pc[4:2], BHT row pc[5:2], slot pc[1]
  task automatic model_update(input bp_addr_pkg::vaddr_t pc, input bp_pred_pkg::target_t tgt,
                              input logic taken, input logic cond);
    int br;
    int hr;
    int s;
    br = int'(pc[4:2]);
    hr = int'(pc[5:2]);
    s  = int'(pc[1]);
    if (taken) begin
      mdl_valid[br][s]  = 1'b1;
      mdl_target[br][s] = tgt;
    end
    // Saturate at 3 and 0
    if (cond && taken && mdl_cnt[hr][s] != 2'd3) mdl_cnt[hr][s] = mdl_cnt[hr][s] + 2'd1;
    if (cond && !taken && mdl_cnt[hr][s] != 2'd0) mdl_cnt[hr][s] = mdl_cnt[hr][s] - 2'd1;
  endtask

  // Drive a fetch address after the edge, compare mid-cycle
  task automatic probe_check(input bp_addr_pkg::vaddr_t addr, input logic exp_taken,
                             input bp_addr_pkg::slot_t exp_slot,
                             input bp_addr_pkg::vaddr_t exp_next);
    @(posedge clk_i);
    #2;
    vpc_i = addr;
    #8;
    check_value("predict_taken_o", 32'(exp_taken), 32'(predict_taken_o));
    // Slot only matters on a taken prediction
    if (exp_taken) check_value("predict_slot_o", 32'(exp_slot), 32'(predict_slot_o));
    check_value("next_pc_o", exp_next, next_pc_o);
  endtask

  task automatic probe_model(input bp_addr_pkg::vaddr_t addr);
    logic                taken;
    bp_addr_pkg::slot_t  slot;
    bp_addr_pkg::vaddr_t nxt;
    int                  br;
    int                  hr;
    br    = int'(addr[4:2]);
    hr    = int'(addr[5:2]);
    taken = 1'b0;
    slot  = '0;
    nxt   = seq_pc(addr);
    // Lowest slot at or after the fetch slot with valid entry and counter >= 2
    for (int s = int'(addr[1]); s < `BP_INSTR_PER_FETCH; s++) begin
      if (!taken && mdl_valid[br][s] && mdl_cnt[hr][s] >= 2'd2) begin
        taken = 1'b1;
        slot  = bp_addr_pkg::slot_t'(s);
        nxt   = mdl_target[br][s];
      end
    end
    probe_check(addr, taken, slot, nxt);
  endtask

  // One four-phase report, with the handshake timing checked
  task automatic send_update(input bp_addr_pkg::vaddr_t pc, input bp_pred_pkg::target_t tgt,
                             input logic taken, input logic cond, input logic dbg);
    int edges;
    int hold;
    @(posedge clk_i);
    #2;
    upd_pc_i     = pc;
    upd_target_i = tgt;
    upd_taken_i  = taken;
    upd_cond_i   = cond;
    debug_mode_i = dbg;
    upd_req_i    = 1'b1;
    edges        = 0;
    do begin
      @(posedge clk_i);
      #2;
      edges++;
    end while (!upd_ack_o && edges < 5);
    if (!upd_ack_o) begin
      proto_errors++;
      $display("Handshake failure at %0t: upd_ack_o did not rise within 5 cycles", $time);
    end else if (edges != 2) begin
      proto_errors++;
      $display("Handshake failure at %0t: upd_ack_o rose %0d edges after req", $time, edges);
    end
    // Tables changed on the edge that raised ack
    if (upd_ack_o && !dbg) model_update(pc, tgt, taken, cond);
    hold = {$random(seed)} % 2;
    repeat (hold) begin
      @(posedge clk_i);
      #2;
      check_value("upd_ack_o", 32'd1, 32'(upd_ack_o));
    end
    upd_req_i    = 1'b0;
    debug_mode_i = 1'b0;
    // Request data may change once req is low
    upd_pc_i     = $random(seed);
    upd_target_i = $random(seed);
    @(posedge clk_i);
    #2;
    check_value("upd_ack_o", 32'd0, 32'(upd_ack_o));
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    bp_addr_pkg::vaddr_t addr;
    bp_addr_pkg::vaddr_t pc_a;
    bp_addr_pkg::vaddr_t pc_b;
    logic [1:0]          cnt_a;
    int                  idx;
    int                  kind;
    seed         = 41;
    value_errors = 0;
    proto_errors = 0;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    debug_mode_i = 1'b0;
    vpc_i        = '0;
    upd_req_i    = 1'b0;
    upd_taken_i  = 1'b0;
    upd_cond_i   = 1'b0;
    upd_pc_i     = '0;
    upd_target_i = '0;
    foreach (mdl_valid[r, s]) mdl_valid[r][s] = 1'b0;
    foreach (mdl_cnt[r, s]) mdl_cnt[r][s] = 2'd1;
    for (int k = 0; k < 6; k++) begin
      addr             = 32'h8000_0000 | ($random(seed) & 32'h0000_007C);
      pc_pool[2*k]     = addr;
      pc_pool[2*k + 1] = addr | 32'h2;
    end
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Empty tables, always sequential
    for (int i = 0; i < 16; i++) begin
      addr = $random(seed);
      probe_check(addr, 1'b0, '0, seq_pc(addr));
    end

    // Slot 1 branch, BTB row 5, trained twice
    pc_a = 32'h8000_0016;
    send_update(pc_a, 32'h8000_0400, 1'b1, 1'b1, 1'b0);
    send_update(pc_a, 32'h8000_0400, 1'b1, 1'b1, 1'b0);
    probe_check(pc_a, 1'b1, 1'b1, 32'h8000_0400);
    probe_check(32'h8000_0014, 1'b1, 1'b1, 32'h8000_0400);
    // Slot 0 branch is skipped when fetch starts at slot 1
    pc_b = 32'h8000_0028;
    send_update(pc_b, 32'h8000_0200, 1'b1, 1'b1, 1'b0);
    send_update(pc_b, 32'h8000_0200, 1'b1, 1'b1, 1'b0);
    probe_check(pc_b, 1'b1, 1'b0, 32'h8000_0200);
    probe_check(32'h8000_002A, 1'b0, '0, 32'h8000_002C);

    // Random taken, not-taken and jump reports
    for (int n = 0; n < N_RAND; n++) begin
      idx  = {$random(seed)} % 12;
      kind = {$random(seed)} % 4;
      addr = $random(seed) & 32'hFFFF_FFFE;
      if (kind < 2) send_update(pc_pool[idx], addr, 1'b1, 1'b1, 1'b0);
      else if (kind == 2) send_update(pc_pool[idx], addr, 1'b0, 1'b1, 1'b0);
      else send_update(pc_pool[idx], addr, 1'b1, 1'b0, 1'b0);
      // Block start sees both slots, so priority is exercised
      probe_model(pc_pool[idx] & 32'hFFFF_FFFC);
      probe_model($random(seed));
    end

    // Valid slot 0 entry with a counter of 1 or more, so a stray write would show
    send_update(pc_pool[0], 32'h8000_0100, 1'b1, 1'b1, 1'b0);
    // Debug mode update leaves the tables alone
    send_update(pc_pool[0], 32'h0BAD_0000, 1'b1, 1'b1, 1'b1);
    probe_model(pc_pool[0] & 32'hFFFF_FFFC);
    probe_model(pc_pool[0]);

    // Flush drops all targets, counters stay
    @(posedge clk_i);
    #2;
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    foreach (mdl_valid[r, s]) mdl_valid[r][s] = 1'b0;
    for (int k = 0; k < 12; k++) probe_check(pc_pool[k], 1'b0, '0, seq_pc(pc_pool[k]));
    cnt_a = mdl_cnt[int'(pc_a[5:2])][int'(pc_a[1])];
    send_update(pc_a, 32'h8000_0800, 1'b1, 1'b1, 1'b0);
    // Kept counter of 1 or more reaches taken after one report
    if (cnt_a >= 2'd1) probe_check(pc_a, 1'b1, 1'b1, 32'h8000_0800);
    else probe_check(pc_a, 1'b0, '0, seq_pc(pc_a));

    $display("Summary: %0d value errors, %0d handshake errors", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: branch_predict_top.sv
// Branch predictor top: BTB, BHT, update controller and next-PC selection
`include "bp_cfg.svh"

module branch_predict_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 debug_mode_i,
  // Fetch side
  input  bp_addr_pkg::vaddr_t  vpc_i,
  output logic                 predict_taken_o,
  output bp_addr_pkg::slot_t   predict_slot_o,
  output bp_addr_pkg::vaddr_t  next_pc_o,
  // Execute side update port
  input  logic                 upd_req_i,
  input  logic                 upd_taken_i,
  input  logic                 upd_cond_i,
  input  bp_addr_pkg::vaddr_t  upd_pc_i,
  input  bp_pred_pkg::target_t upd_target_i,
  output logic                 upd_ack_o
);

  // ------------------------------------------------------------
  // Internal wiring
  // ------------------------------------------------------------
  // Prediction read results
  logic                  [`BP_INSTR_PER_FETCH-1:0] btb_valid;
  bp_pred_pkg::target_t  [`BP_INSTR_PER_FETCH-1:0] btb_target;
  bp_pred_pkg::bht_cnt_t [`BP_INSTR_PER_FETCH-1:0] bht_cnt;

  // Write bus from the update controller
  logic                 btb_we;
  logic                 bht_we;
  bp_addr_pkg::vaddr_t  wr_pc;
  bp_pred_pkg::target_t wr_target;
  logic                 wr_taken;

  bp_update_ctrl i_bp_update_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .debug_mode_i (debug_mode_i),
    .upd_req_i    (upd_req_i),
    .upd_pc_i     (upd_pc_i),
    .upd_target_i (upd_target_i),
    .upd_taken_i  (upd_taken_i),
    .upd_cond_i   (upd_cond_i),
    .upd_ack_o    (upd_ack_o),
    .btb_we_o     (btb_we),
    .bht_we_o     (bht_we),
    .wr_pc_o      (wr_pc),
    .wr_target_o  (wr_target),
    .wr_taken_o   (wr_taken)
  );

  btb i_btb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .rd_pc_i     (vpc_i),
    .wr_en_i     (btb_we),
    .wr_pc_i     (wr_pc),
    .wr_target_i (wr_target),
    .valid_o     (btb_valid),
    .target_o    (btb_target)
  );

  bht i_bht (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_pc_i    (vpc_i),
    .wr_en_i    (bht_we),
    .wr_pc_i    (wr_pc),
    .wr_taken_i (wr_taken),
    .cnt_o      (bht_cnt)
  );

  bp_next_pc i_bp_next_pc (
    .vpc_i           (vpc_i),
    .btb_valid_i     (btb_valid),
    .btb_target_i    (btb_target),
    .bht_cnt_i       (bht_cnt),
    .predict_taken_o (predict_taken_o),
    .predict_slot_o  (predict_slot_o),
    .next_pc_o       (next_pc_o)
  );

endmodule

// File: bp_next_pc.sv
// Next-PC selection: slot masking, lowest taken slot pick, target or sequential address
`include "bp_cfg.svh"

module bp_next_pc (
  input  bp_addr_pkg::vaddr_t                             vpc_i,
  // Per-slot table results for the row of vpc_i
  input  logic                  [`BP_INSTR_PER_FETCH-1:0] btb_valid_i,
  input  bp_pred_pkg::target_t  [`BP_INSTR_PER_FETCH-1:0] btb_target_i,
  input  bp_pred_pkg::bht_cnt_t [`BP_INSTR_PER_FETCH-1:0] bht_cnt_i,
  // Prediction for this fetch
  output logic                                            predict_taken_o,
  output bp_addr_pkg::slot_t                              predict_slot_o,
  output bp_addr_pkg::vaddr_t                             next_pc_o
);

  // Slot that the fetch address points into
  bp_addr_pkg::slot_t  fetch_slot;
  // Slots that would redirect fetch
  logic [`BP_INSTR_PER_FETCH-1:0] slot_hit;
  // Start of the next fetch block
  bp_addr_pkg::vaddr_t seq_pc;

  assign fetch_slot = vpc_i[`BP_SLOT_LSB +: `BP_SLOT_W];

  // Round down to the block, then step one block
  assign seq_pc = (vpc_i & ~bp_addr_pkg::vaddr_t'(`BP_FETCH_BYTES - 1))
                + bp_addr_pkg::vaddr_t'(`BP_FETCH_BYTES);

  // ------------------------------------------------------------
  // Per-slot qualification
  // ------------------------------------------------------------
  // Valid target, counter says taken, slot not before the fetch slot
  always_comb begin
    for (int i = 0; i < `BP_INSTR_PER_FETCH; i++) begin
      slot_hit[i] = btb_valid_i[i]
                  && (bht_cnt_i[i] >= bp_pred_pkg::BHT_TAKEN_MIN)
                  && (i >= int'(fetch_slot));
    end
  end

  // ------------------------------------------------------------
  // Lowest slot wins
  // ------------------------------------------------------------
  always_comb begin
    predict_taken_o = 1'b0;
    predict_slot_o  = '0;
    next_pc_o       = seq_pc;
    // Walk downwards so the lowest hit is assigned last
    for (int i = `BP_INSTR_PER_FETCH - 1; i >= 0; i--) begin
      if (slot_hit[i]) begin
        predict_taken_o = 1'b1;
        predict_slot_o  = bp_addr_pkg::slot_t'(i);
        next_pc_o       = btb_target_i[i];
      end
    end
  end

endmodule

// File: bp_update_ctrl.sv
// Update controller: four-phase req/ack receiver, request latch and one table write per report
`include "bp_cfg.svh"

module bp_update_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Suppresses the table write, handshake still completes
  input  logic                 debug_mode_i,
  // Execute side handshake and resolved branch
  input  logic                 upd_req_i,
  input  bp_addr_pkg::vaddr_t  upd_pc_i,
  input  bp_pred_pkg::target_t upd_target_i,
  input  logic                 upd_taken_i,
  input  logic                 upd_cond_i,
  output logic                 upd_ack_o,
  // Qualified table write
  output logic                 btb_we_o,
  output logic                 bht_we_o,
  output bp_addr_pkg::vaddr_t  wr_pc_o,
  output bp_pred_pkg::target_t wr_target_o,
  output logic                 wr_taken_o
);

  bp_pred_pkg::upd_state_e state_q, state_d;

  // Latched request fields
  bp_addr_pkg::vaddr_t  pc_q;
  bp_pred_pkg::target_t target_q;
  logic                 taken_q;
  logic                 cond_q;

  logic                 accept;

  // New request seen while idle
  assign accept = (state_q == bp_pred_pkg::UPD_IDLE) && upd_req_i;

  // ------------------------------------------------------------
  // Handshake FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      bp_pred_pkg::UPD_IDLE:  if (upd_req_i) state_d = bp_pred_pkg::UPD_WRITE;
      // Tables are written on the edge leaving this state
      bp_pred_pkg::UPD_WRITE: state_d = bp_pred_pkg::UPD_ACK;
      // Hold ack until the requester drops req
      bp_pred_pkg::UPD_ACK:   if (!upd_req_i) state_d = bp_pred_pkg::UPD_IDLE;
      default:                state_d = bp_pred_pkg::UPD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= bp_pred_pkg::UPD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the report once, execute may change it after ack
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pc_q     <= upd_pc_i;
      target_q <= upd_target_i;
      taken_q  <= upd_taken_i;
      cond_q   <= upd_cond_i;
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------
  assign upd_ack_o = (state_q == bp_pred_pkg::UPD_ACK);

  // Taken branches install a target, conditional ones train the counter
  assign btb_we_o = (state_q == bp_pred_pkg::UPD_WRITE) && taken_q && !debug_mode_i;
  assign bht_we_o = (state_q == bp_pred_pkg::UPD_WRITE) && cond_q && !debug_mode_i;

  assign wr_pc_o     = pc_q;
  assign wr_target_o = target_q;
  assign wr_taken_o  = taken_q;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  // Ack only ever follows a write cycle
  a_ack_after_write: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(upd_ack_o) |-> $past(state_q == bp_pred_pkg::UPD_WRITE)
  ) else $error("bp_update_ctrl: ack raised without a write cycle");

  // A table write is always answered by ack on the next cycle
  a_we_then_ack: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (btb_we_o || bht_we_o) |=> upd_ack_o
  ) else $error("bp_update_ctrl: table write not followed by ack");

endmodule

// File: bht.sv
// Branch history table: 2-bit saturating counters, combinational row read, one update per write
`include "bp_cfg.svh"

module bht (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  // Fetch address for the prediction read
  input  bp_addr_pkg::vaddr_t                            rd_pc_i,
  // Write enable, set only for resolved conditional branches
  input  logic                                           wr_en_i,
  input  bp_addr_pkg::vaddr_t                            wr_pc_i,
  // Direction of the resolved branch
  input  logic                                           wr_taken_i,
  // Counters of both slots in the addressed row
  output bp_pred_pkg::bht_cnt_t [`BP_INSTR_PER_FETCH-1:0] cnt_o
);

  bp_addr_pkg::bht_row_t rd_row;
  bp_addr_pkg::bht_row_t wr_row;
  bp_addr_pkg::slot_t    wr_slot;

  // Counter storage per row and slot
  bp_pred_pkg::bht_cnt_t cnt_q [`BP_BHT_ROWS][`BP_INSTR_PER_FETCH];

  // Current and next value of the counter being written
  bp_pred_pkg::bht_cnt_t cnt_cur;
  bp_pred_pkg::bht_cnt_t cnt_nxt;

  // ------------------------------------------------------------
  // Index decode
  // ------------------------------------------------------------
  assign rd_row  = rd_pc_i[`BP_ROW_LSB +: `BP_BHT_ROW_W];
  assign wr_row  = wr_pc_i[`BP_ROW_LSB +: `BP_BHT_ROW_W];
  assign wr_slot = wr_pc_i[`BP_SLOT_LSB +: `BP_SLOT_W];

  // Row read for the fetch address
  always_comb begin
    for (int i = 0; i < `BP_INSTR_PER_FETCH; i++) begin
      cnt_o[i] = cnt_q[rd_row][i];
    end
  end

  // ------------------------------------------------------------
  // Saturating step
  // ------------------------------------------------------------
  always_comb begin
    cnt_cur = cnt_q[wr_row][wr_slot];
    cnt_nxt = cnt_cur;
    if (wr_taken_i) begin
      // Count up, hold at 3
      if (cnt_cur != bp_pred_pkg::BHT_CNT_MAX) cnt_nxt = cnt_cur + 2'd1;
    end else begin
      // Count down, hold at 0
      if (cnt_cur != '0) cnt_nxt = cnt_cur - 2'd1;
    end
  end

  // Counter registers, weakly not taken out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < `BP_BHT_ROWS; r++) begin
        for (int s = 0; s < `BP_INSTR_PER_FETCH; s++) begin
          cnt_q[r][s] <= bp_pred_pkg::BHT_CNT_INIT;
        end
      end
    end else if (wr_en_i) begin
      cnt_q[wr_row][wr_slot] <= cnt_nxt;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  // Written counter moves only in the resolved direction, so it never wraps
  a_cnt_no_wrap: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wr_en_i |=> ($past(wr_taken_i)
                 ? (cnt_q[$past(wr_row)][$past(wr_slot)] >= $past(cnt_cur))
                 : (cnt_q[$past(wr_row)][$past(wr_slot)] <= $past(cnt_cur)))
  ) else $error("bht: counter left its range after a write");

endmodule

// File: btb.sv
// Register-based branch target buffer: combinational row read, single-slot write, flush
`include "bp_cfg.svh"

module btb (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  // Clears every valid bit, wins over a write
  input  logic                                               flush_i,
  // Fetch address for the prediction read
  input  bp_addr_pkg::vaddr_t                                rd_pc_i,
  // Write enable, already qualified by the update controller
  input  logic                                               wr_en_i,
  input  bp_addr_pkg::vaddr_t                                wr_pc_i,
  input  bp_pred_pkg::target_t                               wr_target_i,
  // Both slots of the addressed row
  output logic                 [`BP_INSTR_PER_FETCH-1:0]     valid_o,
  output bp_pred_pkg::target_t [`BP_INSTR_PER_FETCH-1:0]     target_o
);

  // Row and slot of the read and write addresses
  bp_addr_pkg::btb_row_t rd_row;
  bp_addr_pkg::btb_row_t wr_row;
  bp_addr_pkg::slot_t    wr_slot;

  // Valid bits per row and slot
  logic [`BP_BTB_ROWS-1:0][`BP_INSTR_PER_FETCH-1:0] valid_q;
  // Target payload per row and slot
  bp_pred_pkg::target_t target_q [`BP_BTB_ROWS][`BP_INSTR_PER_FETCH];

  // ------------------------------------------------------------
  // Index decode
  // ------------------------------------------------------------
  assign rd_row  = rd_pc_i[`BP_ROW_LSB +: `BP_BTB_ROW_W];
  assign wr_row  = wr_pc_i[`BP_ROW_LSB +: `BP_BTB_ROW_W];
  assign wr_slot = wr_pc_i[`BP_SLOT_LSB +: `BP_SLOT_W];

  // ------------------------------------------------------------
  // Prediction read
  // ------------------------------------------------------------
  // Whole row goes out, the slot choice is made downstream
  always_comb begin
    valid_o = valid_q[rd_row];
    for (int i = 0; i < `BP_INSTR_PER_FETCH; i++) begin
      target_o[i] = target_q[rd_row][i];
    end
  end

  // ------------------------------------------------------------
  // Valid bits
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      // Evict every entry
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[wr_row][wr_slot] <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Targets
  // ------------------------------------------------------------
  // A target is only visible once its valid bit is set
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      target_q[wr_row][wr_slot] <= wr_target_i;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  // Write address from the update controller must be known
  a_wr_addr_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wr_en_i |-> !$isunknown(wr_pc_i)
  ) else $error("btb: unknown write address with wr_en_i high");

endmodule

// File: bp_pred_pkg.sv
// Prediction package: target and counter typedefs, counter constants, update FSM states
`include "bp_cfg.svh"

package bp_pred_pkg;

  // ------------------------------------------------------------
  // Prediction side types
  // ------------------------------------------------------------
  // Predicted branch target
  typedef logic [`BP_VLEN-1:0] target_t;

  // 2-bit saturating counter, MSB set means taken
  typedef logic [1:0] bht_cnt_t;

  // Weakly not taken after reset
  localparam bht_cnt_t BHT_CNT_INIT = 2'd1;
  // Lowest value predicted as taken
  localparam bht_cnt_t BHT_TAKEN_MIN = 2'd2;
  // Saturation limit
  localparam bht_cnt_t BHT_CNT_MAX = 2'd3;

  // Update controller FSM
  typedef enum logic [1:0] {
    UPD_IDLE  = 2'd0,
    UPD_WRITE = 2'd1,
    UPD_ACK   = 2'd2
  } upd_state_e;

endpackage

// File: bp_addr_pkg.sv
// Address package: fetch address, BTB and BHT row index and slot typedefs
`include "bp_cfg.svh"

package bp_addr_pkg;

  // ------------------------------------------------------------
  // Address side types
  // ------------------------------------------------------------
  // Fetch or branch address
  typedef logic [`BP_VLEN-1:0] vaddr_t;

  // BTB row, address bits 4..2 for 8 rows
  typedef logic [`BP_BTB_ROW_W-1:0] btb_row_t;

  // BHT row, address bits 5..2 for 16 rows
  typedef logic [`BP_BHT_ROW_W-1:0] bht_row_t;

  // Slot inside a fetch block, address bit 1
  // Bit 0 is always zero with 2-byte aligned code
  typedef logic [`BP_SLOT_W-1:0] slot_t;

endpackage

// File: bp_cfg.svh
// Branch predictor configuration macros: address width, fetch slots, table depths
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// ------------------------------------------------------------
// Base configuration
// ------------------------------------------------------------
// Fetch and branch address width
`define BP_VLEN 32
// Compressed 16-bit slots per fetch block
`define BP_INSTR_PER_FETCH 2
// Table entry counts, over all slots
`define BP_BTB_ENTRIES 16
`define BP_BHT_ENTRIES 32

// ------------------------------------------------------------
// Derived geometry
// ------------------------------------------------------------
`define BP_BTB_ROWS (`BP_BTB_ENTRIES / `BP_INSTR_PER_FETCH)
`define BP_BHT_ROWS (`BP_BHT_ENTRIES / `BP_INSTR_PER_FETCH)
`define BP_BTB_ROW_W $clog2(`BP_BTB_ROWS)
`define BP_BHT_ROW_W $clog2(`BP_BHT_ROWS)
// Slot index sits right above the 2-byte alignment bit
`define BP_SLOT_W $clog2(`BP_INSTR_PER_FETCH)
`define BP_SLOT_LSB 1
`define BP_ROW_LSB (`BP_SLOT_LSB + `BP_SLOT_W)
// Bytes covered by one fetch block
`define BP_FETCH_BYTES (`BP_INSTR_PER_FETCH * 2)

`endif
